// ==== Makefile ====
# Verilator flow for the fetch target queue

VERILATOR ?= verilator
TB_TOP    ?= ftq_tb
RTL_TOP   ?= ftq_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --assert

PASS_MSG  := Simulation completed successfully

RTL_SRCS  := source/frontend_pkg.sv source/ftq_ptr_ctrl.sv \
             source/ftq_block_array.sv source/ftq_meta_ram.sv source/ftq_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
source/frontend_pkg.sv
source/ftq_ptr_ctrl.sv
source/ftq_block_array.sv
source/ftq_meta_ram.sv
source/ftq_top.sv
tests/tb_clock_gen.sv
tests/ftq_tb.sv

// ==== source/frontend_pkg.sv ====
package frontend_pkg;

    // Queue geometry
    localparam int ADDR_WIDTH = 32;
    localparam int QUEUE_SIZE = 16;
    localparam int PTR_WIDTH = 4;

    // Backend retires up to this many blocks per cycle
    localparam int COMMIT_WIDTH = 2;
    localparam int COMMIT_CNT_WIDTH = $clog2(COMMIT_WIDTH) + 1;

    localparam int CTR_WIDTH = 2;
    localparam int LEN_WIDTH = 3;

    // One fetch block as produced by the predictor
    typedef struct packed {
        logic                  valid;
        logic                  is_cross_cacheline;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic [LEN_WIDTH-1:0]  length;
        logic                  predicted_taken;
    } ftq_block_t;

    // Metadata that rides along with P1
    typedef struct packed {
        logic                 ftb_hit;
        logic [CTR_WIDTH-1:0] provider_ctr_bits;
    } bpu_meta_t;

    // What the backend knows about the retired branch
    typedef struct packed {
        logic is_branch;
        logic is_conditional;
        logic is_taken;
        logic predicted_taken;
    } backend_commit_meta_t;

    // Training record sent back to the predictor
    typedef struct packed {
        logic                  valid;
        logic                  ftb_hit;
        logic                  is_branch;
        logic                  is_conditional;
        logic                  is_taken;
        logic                  predicted_taken;
        logic [ADDR_WIDTH-1:0] start_pc;
        logic                  is_cross_cacheline;
        logic [CTR_WIDTH-1:0]  provider_ctr_bits;
        logic [ADDR_WIDTH-1:0] jump_target_address;
        logic [ADDR_WIDTH-1:0] fall_through_address;
    } bpu_train_t;

    // Pointer bundle from the pointer control to both arrays
    typedef struct packed {
        logic [PTR_WIDTH-1:0]        bpu_ptr;
        logic [PTR_WIDTH-1:0]        ifu_ptr;
        logic [PTR_WIDTH-1:0]        comm_ptr;
        // P1 rewrites the entry at bpu_ptr - 1
        logic                        p1_override;
        logic [COMMIT_CNT_WIDTH-1:0] commit_num;
    } ptr_state_t;

endpackage

// ==== source/ftq_block_array.sv ====
`timescale 1ns/1ps

module ftq_block_array (
    input  logic                               clk,
    input  logic                               rst,
    input  frontend_pkg::ptr_state_t           ptr_i,
    input  frontend_pkg::ftq_block_t           bpu_p0_i,
    input  frontend_pkg::ftq_block_t           bpu_p1_i,
    input  logic                               backend_flush_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0] backend_flush_ftq_id_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0] commit_id_i,
    output frontend_pkg::ftq_block_t           head_block_o,
    output frontend_pkg::ftq_block_t           commit_block_o
);

    frontend_pkg::ftq_block_t [frontend_pkg::QUEUE_SIZE-1:0] entries_q;
    frontend_pkg::ftq_block_t [frontend_pkg::QUEUE_SIZE-1:0] entries_d;

    logic [frontend_pkg::PTR_WIDTH-1:0] p1_idx;
    logic [frontend_pkg::PTR_WIDTH-1:0] flush_first;
    logic [frontend_pkg::PTR_WIDTH-1:0] flush_span;

    // Override goes back one slot, otherwise P1 lands in a fresh slot
    assign p1_idx = ptr_i.p1_override ? ptr_i.bpu_ptr - frontend_pkg::PTR_WIDTH'(1)
                                      : ptr_i.bpu_ptr;

    // Flushed window runs from the entry after the flush id up to comm_ptr
    assign flush_first = backend_flush_ftq_id_i + frontend_pkg::PTR_WIDTH'(1);
    assign flush_span  = ptr_i.comm_ptr - flush_first;

    always_comb begin
        entries_d = entries_q;

        // Retired blocks free their slots
        for (int i = 0; i < frontend_pkg::COMMIT_WIDTH; i++) begin
            if (i < int'(ptr_i.commit_num)) begin
                entries_d[frontend_pkg::PTR_WIDTH'(ptr_i.comm_ptr
                    + frontend_pkg::PTR_WIDTH'(i))] = '0;
            end
        end

        // P0 is dropped when P1 rewrites the previous block
        if (bpu_p0_i.valid & ~ptr_i.p1_override) begin
            entries_d[ptr_i.bpu_ptr] = bpu_p0_i;
        end

        if (bpu_p1_i.valid) begin
            entries_d[p1_idx] = bpu_p1_i;
        end

        // Everything younger than the flush id is wrong path
        if (backend_flush_i) begin
            for (int i = 0; i < frontend_pkg::QUEUE_SIZE; i++) begin
                if (frontend_pkg::PTR_WIDTH'(frontend_pkg::PTR_WIDTH'(i) - flush_first)
                        < flush_span) begin
                    entries_d[i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entries_q <= '0;
        end else begin
            entries_q <= entries_d;
        end
    end

    // Combinational reads of registered entries
    assign head_block_o   = entries_q[ptr_i.ifu_ptr];
    assign commit_block_o = entries_q[commit_id_i];

endmodule

// ==== source/ftq_meta_ram.sv ====
`timescale 1ns/1ps

module ftq_meta_ram (
    input  logic                                clk,
    input  logic                                rst,
    input  frontend_pkg::ptr_state_t            ptr_i,
    input  logic                                bpu_p0_valid_i,
    input  logic                                bpu_p1_valid_i,
    input  frontend_pkg::bpu_meta_t             bpu_meta_i,
    input  logic                                meta_update_valid_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]  meta_update_id_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] jump_target_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] fall_through_i,
    input  logic                                commit_bitmask_lsb_i,
    input  frontend_pkg::backend_commit_meta_t  commit_meta_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]  commit_id_i,
    input  frontend_pkg::ftq_block_t            commit_block_i,
    output frontend_pkg::bpu_train_t            train_o
);

    typedef struct packed {
        logic                                ftb_hit;
        logic [frontend_pkg::CTR_WIDTH-1:0]  provider_ctr_bits;
        logic [frontend_pkg::ADDR_WIDTH-1:0] jump_target;
        logic [frontend_pkg::ADDR_WIDTH-1:0] fall_through;
    } meta_entry_t;

    meta_entry_t meta_q [frontend_pkg::QUEUE_SIZE];
    meta_entry_t p1_entry;
    meta_entry_t commit_entry;

    logic [frontend_pkg::PTR_WIDTH-1:0] p1_idx;
    logic train_fire;

    // Same slot choice as the block array
    assign p1_idx = ptr_i.p1_override ? ptr_i.bpu_ptr - frontend_pkg::PTR_WIDTH'(1)
                                      : ptr_i.bpu_ptr;

    // Fresh entry from P1, targets wait for the backend
    assign p1_entry.ftb_hit           = bpu_meta_i.ftb_hit;
    assign p1_entry.provider_ctr_bits = bpu_meta_i.provider_ctr_bits;
    assign p1_entry.jump_target       = '0;
    assign p1_entry.fall_through      = '0;

    always_ff @(posedge clk) begin
        if (bpu_p1_valid_i) begin
            meta_q[p1_idx] <= p1_entry;
        end else if (bpu_p0_valid_i) begin
            // No main predictor info for this block
            meta_q[ptr_i.bpu_ptr] <= '0;
        end

        // Resolved targets from the backend
        if (meta_update_valid_i) begin
            meta_q[meta_update_id_i].jump_target  <= jump_target_i;
            meta_q[meta_update_id_i].fall_through <= fall_through_i;
        end
    end

    assign commit_entry = meta_q[commit_id_i];

    // Only the oldest commit slot trains the predictor
    assign train_fire = commit_bitmask_lsb_i & commit_meta_i.is_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            train_o <= '0;
        end else if (train_fire) begin
            train_o.valid                <= 1'b1;
            train_o.ftb_hit              <= commit_entry.ftb_hit;
            train_o.is_branch            <= commit_meta_i.is_branch;
            train_o.is_conditional       <= commit_meta_i.is_conditional;
            train_o.is_taken             <= commit_meta_i.is_taken;
            train_o.predicted_taken      <= commit_meta_i.predicted_taken;
            train_o.start_pc             <= commit_block_i.start_pc;
            train_o.is_cross_cacheline   <= commit_block_i.is_cross_cacheline;
            train_o.provider_ctr_bits    <= commit_entry.provider_ctr_bits;
            train_o.jump_target_address  <= commit_entry.jump_target;
            train_o.fall_through_address <= commit_entry.fall_through;
        end else begin
            train_o <= '0;
        end
    end

endmodule

// ==== source/ftq_ptr_ctrl.sv ====
`timescale 1ns/1ps

module ftq_ptr_ctrl (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      bpu_p0_valid_i,
    input  logic                                      bpu_p1_valid_i,
    input  logic                                      ifu_accept_i,
    input  logic                                      head_valid_i,
    input  logic                                      backend_flush_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]        backend_flush_ftq_id_i,
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0]     backend_commit_bitmask_i,
    output frontend_pkg::ptr_state_t                  ptr_o,
    output logic                                      queue_full_o,
    output logic                                      frontend_redirect_o
);

    logic [frontend_pkg::PTR_WIDTH-1:0] bpu_ptr;
    logic [frontend_pkg::PTR_WIDTH-1:0] ifu_ptr;
    logic [frontend_pkg::PTR_WIDTH-1:0] comm_ptr;
    logic [frontend_pkg::PTR_WIDTH-1:0] bpu_ptr_next;
    logic [frontend_pkg::PTR_WIDTH-1:0] bpu_ptr_prev;
    logic [frontend_pkg::PTR_WIDTH-1:0] flush_next;
    logic [frontend_pkg::PTR_WIDTH-1:0] occupancy;
    logic [frontend_pkg::COMMIT_CNT_WIDTH-1:0] commit_num;

    logic queue_full;
    logic queue_full_q;
    logic ifu_send;
    logic ifu_send_q;
    logic p1_override;
    logic redirect;

    // Popcount of the commit bitmask
    always_comb begin
        commit_num = '0;
        for (int i = 0; i < frontend_pkg::COMMIT_WIDTH; i++) begin
            commit_num = commit_num
                + frontend_pkg::COMMIT_CNT_WIDTH'(backend_commit_bitmask_i[i]);
        end
    end

    assign bpu_ptr_next = bpu_ptr + frontend_pkg::PTR_WIDTH'(1);
    assign bpu_ptr_prev = bpu_ptr - frontend_pkg::PTR_WIDTH'(1);
    assign flush_next   = backend_flush_ftq_id_i + frontend_pkg::PTR_WIDTH'(1);
    assign occupancy    = bpu_ptr - comm_ptr;

    // One slot is kept free so that full and empty differ
    assign queue_full = (bpu_ptr_next == comm_ptr);

    assign ifu_send = head_valid_i & ifu_accept_i;

    // P0 was taken last cycle, so P1 refines that same block
    assign p1_override = bpu_p1_valid_i & ~queue_full_q;

    // Rewritten block is the one the IFU is taking now or took last cycle
    assign redirect = p1_override & (bpu_ptr_prev == ifu_ptr) & (ifu_send | ifu_send_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            queue_full_q <= 1'b0;
            ifu_send_q   <= 1'b0;
        end else begin
            queue_full_q <= queue_full;
            ifu_send_q   <= ifu_send;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bpu_ptr  <= '0;
            ifu_ptr  <= '0;
            comm_ptr <= '0;
        end else begin
            comm_ptr <= comm_ptr + frontend_pkg::PTR_WIDTH'(commit_num);

            // IFU stays on the rewritten block after a redirect
            if (ifu_send & ~redirect) begin
                ifu_ptr <= ifu_ptr + frontend_pkg::PTR_WIDTH'(1);
            end

            if (bpu_p0_valid_i & ~p1_override) begin
                bpu_ptr <= bpu_ptr_next;
            end

            // Restart right after the mispredicted block
            if (backend_flush_i) begin
                ifu_ptr <= flush_next;
                bpu_ptr <= flush_next;
            end
        end
    end

    assign ptr_o.bpu_ptr     = bpu_ptr;
    assign ptr_o.ifu_ptr     = ifu_ptr;
    assign ptr_o.comm_ptr    = comm_ptr;
    assign ptr_o.p1_override = p1_override;
    assign ptr_o.commit_num  = commit_num;

    assign queue_full_o        = queue_full;
    assign frontend_redirect_o = redirect;

    // Predictor must stall while the queue reports full
    assert property (@(posedge clk) disable iff (rst) bpu_p0_valid_i |-> !queue_full)
        else $error("P0 block while queue is full");

    // IFU only accepts a block that is on its port
    assert property (@(posedge clk) disable iff (rst) ifu_accept_i |-> head_valid_i)
        else $error("IFU accept without a valid head block");

    // Backend never retires blocks that were not predicted
    assert property (@(posedge clk) disable iff (rst)
        frontend_pkg::PTR_WIDTH'(commit_num) <= occupancy)
        else $error("Commit count exceeds queue occupancy");

endmodule

// ==== source/ftq_top.sv ====
`timescale 1ns/1ps

module ftq_top (
    input  logic                                  clk,
    input  logic                                  rst,

    // Predictor
    input  frontend_pkg::ftq_block_t              bpu_p0_i,
    input  frontend_pkg::ftq_block_t              bpu_p1_i,
    input  frontend_pkg::bpu_meta_t               bpu_meta_i,
    output logic                                  bpu_queue_full_o,
    output frontend_pkg::bpu_train_t              bpu_train_o,

    // IFU, accept comes back in the same cycle
    output frontend_pkg::ftq_block_t              ifu_o,
    output logic [frontend_pkg::PTR_WIDTH-1:0]    ifu_ftq_id_o,
    output logic                                  ifu_frontend_redirect_o,
    input  logic                                  ifu_accept_i,

    // Backend
    input  logic                                  backend_flush_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]    backend_flush_ftq_id_i,
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0] backend_commit_bitmask_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]    backend_commit_ftq_id_i,
    input  frontend_pkg::backend_commit_meta_t    backend_commit_meta_i,
    input  logic                                  backend_meta_update_valid_i,
    input  logic [frontend_pkg::PTR_WIDTH-1:0]    backend_meta_update_id_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0]   backend_jump_target_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0]   backend_fall_through_i
);

    frontend_pkg::ptr_state_t ptr_state;
    frontend_pkg::ftq_block_t head_block;
    frontend_pkg::ftq_block_t commit_block;

    ftq_ptr_ctrl u_ptr_ctrl (
        .clk                      (clk),
        .rst                      (rst),
        .bpu_p0_valid_i           (bpu_p0_i.valid),
        .bpu_p1_valid_i           (bpu_p1_i.valid),
        .ifu_accept_i             (ifu_accept_i),
        .head_valid_i             (head_block.valid),
        .backend_flush_i          (backend_flush_i),
        .backend_flush_ftq_id_i   (backend_flush_ftq_id_i),
        .backend_commit_bitmask_i (backend_commit_bitmask_i),
        .ptr_o                    (ptr_state),
        .queue_full_o             (bpu_queue_full_o),
        .frontend_redirect_o      (ifu_frontend_redirect_o)
    );

    ftq_block_array u_block_array (
        .clk                    (clk),
        .rst                    (rst),
        .ptr_i                  (ptr_state),
        .bpu_p0_i               (bpu_p0_i),
        .bpu_p1_i               (bpu_p1_i),
        .backend_flush_i        (backend_flush_i),
        .backend_flush_ftq_id_i (backend_flush_ftq_id_i),
        .commit_id_i            (backend_commit_ftq_id_i),
        .head_block_o           (head_block),
        .commit_block_o         (commit_block)
    );

    ftq_meta_ram u_meta_ram (
        .clk                  (clk),
        .rst                  (rst),
        .ptr_i                (ptr_state),
        .bpu_p0_valid_i       (bpu_p0_i.valid),
        .bpu_p1_valid_i       (bpu_p1_i.valid),
        .bpu_meta_i           (bpu_meta_i),
        .meta_update_valid_i  (backend_meta_update_valid_i),
        .meta_update_id_i     (backend_meta_update_id_i),
        .jump_target_i        (backend_jump_target_i),
        .fall_through_i       (backend_fall_through_i),
        .commit_bitmask_lsb_i (backend_commit_bitmask_i[0]),
        .commit_meta_i        (backend_commit_meta_i),
        .commit_id_i          (backend_commit_ftq_id_i),
        .commit_block_i       (commit_block),
        .train_o              (bpu_train_o)
    );

    assign ifu_o        = head_block;
    assign ifu_ftq_id_o = ptr_state.ifu_ptr;

endmodule

// ==== tests/ftq_tb.sv ====
`timescale 1ns/1ps

module ftq_tb;

    localparam int PW = frontend_pkg::PTR_WIDTH;
    // Roughly four times the scheduled stimulus of about 450 cycles
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic rst;

    frontend_pkg::ftq_block_t           bpu_p0;
    frontend_pkg::ftq_block_t           bpu_p1;
    frontend_pkg::bpu_meta_t            bpu_meta;
    frontend_pkg::bpu_train_t           train;
    frontend_pkg::ftq_block_t           ifu_block;
    frontend_pkg::backend_commit_meta_t commit_meta;
    logic [PW-1:0]                         ifu_id;
    logic [PW-1:0]                         flush_id;
    logic [PW-1:0]                         commit_id;
    logic [PW-1:0]                         upd_id;
    logic [frontend_pkg::COMMIT_WIDTH-1:0] commit_mask;
    logic [frontend_pkg::ADDR_WIDTH-1:0]   upd_jump;
    logic [frontend_pkg::ADDR_WIDTH-1:0]   upd_fall;
    logic                                  queue_full;
    logic                                  redirect;
    logic                                  ifu_accept;
    logic                                  flush;
    logic                                  upd_valid;

    // Reference model of the queue
    frontend_pkg::ftq_block_t            m_blk  [frontend_pkg::QUEUE_SIZE];
    frontend_pkg::bpu_meta_t             m_meta [frontend_pkg::QUEUE_SIZE];
    logic [frontend_pkg::ADDR_WIDTH-1:0] m_jump [frontend_pkg::QUEUE_SIZE];
    logic [frontend_pkg::ADDR_WIDTH-1:0] m_fall [frontend_pkg::QUEUE_SIZE];
    logic [PW-1:0]                       m_bpu;
    logic [PW-1:0]                       m_ifu;
    logic [PW-1:0]                       m_comm;
    logic                                m_full_q;
    logic                                m_send_q;
    frontend_pkg::bpu_train_t            m_train;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int redirects_seen = 0;
    int fulls_seen = 0;
    int trains_seen = 0;

    // Name of the test that drives the current cycle
    string test_name = "reset";

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    ftq_top u_dut (
        .clk                         (clk),
        .rst                         (rst),
        .bpu_p0_i                    (bpu_p0),
        .bpu_p1_i                    (bpu_p1),
        .bpu_meta_i                  (bpu_meta),
        .bpu_queue_full_o            (queue_full),
        .bpu_train_o                 (train),
        .ifu_o                       (ifu_block),
        .ifu_ftq_id_o                (ifu_id),
        .ifu_frontend_redirect_o     (redirect),
        .ifu_accept_i                (ifu_accept),
        .backend_flush_i             (flush),
        .backend_flush_ftq_id_i      (flush_id),
        .backend_commit_bitmask_i    (commit_mask),
        .backend_commit_ftq_id_i     (commit_id),
        .backend_commit_meta_i       (commit_meta),
        .backend_meta_update_valid_i (upd_valid),
        .backend_meta_update_id_i    (upd_id),
        .backend_jump_target_i       (upd_jump),
        .backend_fall_through_i      (upd_fall)
    );

    function automatic void reset_model();
        for (int i = 0; i < frontend_pkg::QUEUE_SIZE; i++) begin
            m_blk[i] = '0;
        end
        m_bpu    = '0;
        m_ifu    = '0;
        m_comm   = '0;
        m_full_q = 1'b0;
        m_send_q = 1'b0;
        m_train  = '0;
    endfunction

    function automatic logic model_full();
        return (m_bpu + PW'(1)) == m_comm;
    endfunction

    // Rewrite of the block the IFU is taking now or took a cycle ago
    function automatic logic model_redirect();
        logic p1_ovr;
        p1_ovr = bpu_p1.valid & ~m_full_q;
        return p1_ovr & ((m_bpu - PW'(1)) == m_ifu)
            & ((ifu_accept & m_blk[m_ifu].valid) | m_send_q);
    endfunction

    function automatic frontend_pkg::bpu_train_t build_train();
        frontend_pkg::bpu_train_t t;
        t = '0;
        if (commit_mask[0] && commit_meta.is_branch) begin
            t.valid                = 1'b1;
            t.ftb_hit              = m_meta[commit_id].ftb_hit;
            t.is_branch            = commit_meta.is_branch;
            t.is_conditional       = commit_meta.is_conditional;
            t.is_taken             = commit_meta.is_taken;
            t.predicted_taken      = commit_meta.predicted_taken;
            t.start_pc             = m_blk[commit_id].start_pc;
            t.is_cross_cacheline   = m_blk[commit_id].is_cross_cacheline;
            t.provider_ctr_bits    = m_meta[commit_id].provider_ctr_bits;
            t.jump_target_address  = m_jump[commit_id];
            t.fall_through_address = m_fall[commit_id];
        end
        return t;
    endfunction

    // Apply one cycle of inputs to the model
    function automatic void step_model();
        logic          full_now;
        logic          p1_ovr;
        logic          send;
        logic          redir;
        logic [PW-1:0] p1_idx;
        logic [PW-1:0] idx;
        full_now = model_full();
        p1_ovr   = bpu_p1.valid & ~m_full_q;
        send     = ifu_accept & m_blk[m_ifu].valid;
        redir    = model_redirect();
        p1_idx   = p1_ovr ? m_bpu - PW'(1) : m_bpu;
        m_train  = build_train();

        idx = m_comm;
        for (int i = 0; i < $countones(commit_mask); i++) begin
            m_blk[idx] = '0;
            idx = idx + PW'(1);
        end
        if (bpu_p0.valid && !p1_ovr) begin
            m_blk[m_bpu] = bpu_p0;
        end
        if (bpu_p1.valid) begin
            m_blk[p1_idx]  = bpu_p1;
            m_meta[p1_idx] = bpu_meta;
            m_jump[p1_idx] = '0;
            m_fall[p1_idx] = '0;
        end else if (bpu_p0.valid) begin
            m_meta[m_bpu] = '0;
            m_jump[m_bpu] = '0;
            m_fall[m_bpu] = '0;
        end
        if (upd_valid) begin
            m_jump[upd_id] = upd_jump;
            m_fall[upd_id] = upd_fall;
        end
        // Wrong path runs from the flush id up to the oldest live block
        if (flush) begin
            idx = flush_id + PW'(1);
            while (idx != m_comm) begin
                m_blk[idx] = '0;
                idx = idx + PW'(1);
            end
        end

        m_comm = m_comm + PW'($countones(commit_mask));
        if (send && !redir) begin
            m_ifu = m_ifu + PW'(1);
        end
        if (bpu_p0.valid && !p1_ovr) begin
            m_bpu = m_bpu + PW'(1);
        end
        if (flush) begin
            m_ifu = flush_id + PW'(1);
            m_bpu = flush_id + PW'(1);
        end
        m_full_q = full_now;
        m_send_q = send;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("Fail %s %s: expected %h, actual %h at %0t",
                 test_name, name, exp_v, act_v, $time);
    endtask

    // Sampled 1 ns after the inputs change and well before the next edge
    always @(negedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            checks++;
            if (ifu_block !== m_blk[m_ifu]) begin
                report_mismatch("ifu_o", 128'(m_blk[m_ifu]), 128'(ifu_block));
            end
            if (ifu_id !== m_ifu) begin
                report_mismatch("ifu_ftq_id_o", 128'(m_ifu), 128'(ifu_id));
            end
            if (redirect !== model_redirect()) begin
                report_mismatch("redirect", 128'(model_redirect()), 128'(redirect));
            end
            if (queue_full !== model_full()) begin
                report_mismatch("queue_full", 128'(model_full()), 128'(queue_full));
            end
            if (train !== m_train) begin
                report_mismatch("bpu_train_o", 128'(m_train), 128'(train));
            end
            redirects_seen += int'(redirect === 1'b1);
            fulls_seen += int'(queue_full === 1'b1);
            trains_seen += int'(train.valid === 1'b1);
            step_model();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic frontend_pkg::ftq_block_t rand_block();
        frontend_pkg::ftq_block_t b;
        b.valid              = 1'b1;
        b.is_cross_cacheline = 1'($urandom);
        b.start_pc           = frontend_pkg::ADDR_WIDTH'($urandom);
        b.length             = frontend_pkg::LEN_WIDTH'($urandom);
        b.predicted_taken    = 1'($urandom);
        return b;
    endfunction

    function automatic frontend_pkg::bpu_meta_t rand_meta();
        return frontend_pkg::bpu_meta_t'(3'($urandom));
    endfunction

    function automatic void clear_inputs();
        bpu_p0      = '0;
        bpu_p1      = '0;
        bpu_meta    = '0;
        ifu_accept  = 1'b0;
        flush       = 1'b0;
        commit_mask = '0;
        commit_meta = '0;
        upd_valid   = 1'b0;
    endfunction

    // Step to 1 ns past the next rising edge with all strobes idle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    task automatic push_blocks(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            if (!model_full()) begin
                bpu_p0 = rand_block();
            end
        end
    endtask

    // IFU drains every block up to the predictor pointer
    task automatic accept_blocks();
        next_cycle();
        while (m_blk[m_ifu].valid && m_ifu != m_bpu) begin
            ifu_accept = 1'b1;
            next_cycle();
        end
    endtask

    task automatic commit_one(input logic branch);
        commit_id   = m_comm;
        commit_mask = 2'b01;
        if (m_comm + PW'(1) != m_ifu && m_blk[m_comm + PW'(1)].valid) begin
            commit_mask = 2'b11;
        end
        commit_meta = frontend_pkg::backend_commit_meta_t'(4'($urandom));
        commit_meta.is_branch = branch;
    endtask

    task automatic commit_blocks(input logic branch);
        next_cycle();
        while (m_comm != m_ifu && m_blk[m_comm].valid) begin
            commit_one(branch);
            next_cycle();
        end
    endtask

    // Mixed traffic with overrides, target updates and training
    task automatic random_traffic(input int n);
        logic p0_taken;
        p0_taken = 1'b0;
        for (int i = 0; i < n; i++) begin
            next_cycle();
            if (p0_taken && $urandom_range(2) == 0) begin
                bpu_p1   = rand_block();
                bpu_meta = rand_meta();
            end
            if (!model_full() && $urandom_range(1) == 0) begin
                bpu_p0 = rand_block();
            end
            p0_taken = bpu_p0.valid & ~bpu_p1.valid;
            if (m_blk[m_ifu].valid && m_ifu != m_bpu && $urandom_range(2) != 0) begin
                ifu_accept = 1'b1;
            end
            if (m_comm != m_ifu && m_blk[m_comm].valid && $urandom_range(1) == 0) begin
                commit_one(1'($urandom));
            end
            if (m_blk[m_comm].valid && $urandom_range(3) == 0) begin
                upd_valid = 1'b1;
                upd_id    = m_comm;
                upd_jump  = $urandom;
                upd_fall  = $urandom;
            end
        end
    endtask

    initial begin
        void'($urandom(91));
        clear_inputs();
        flush_id  = '0;
        commit_id = '0;
        upd_id    = '0;
        upd_jump  = '0;
        upd_fall  = '0;
        @(negedge rst);

        // Streaming while the IFU holds off for two cycles
        test_name = "streaming";
        push_blocks(3);
        repeat (2) next_cycle();
        accept_blocks();
        commit_blocks(1'b0);

        // Fill the queue, then P1 after a full cycle takes a fresh slot
        test_name = "full_commit";
        push_blocks(15);
        next_cycle();
        next_cycle();
        bpu_p1   = rand_block();
        bpu_meta = rand_meta();
        accept_blocks();
        commit_blocks(1'b1);

        // P1 replaces the last P0 block and drops the P0 beside it
        test_name = "p1_override";
        next_cycle();
        bpu_p0 = rand_block();
        next_cycle();
        bpu_p1   = rand_block();
        bpu_meta = rand_meta();
        bpu_p0   = rand_block();
        next_cycle();
        ifu_accept = 1'b1;
        bpu_p0     = rand_block();
        // Rewrite of the block being accepted
        next_cycle();
        ifu_accept = 1'b1;
        bpu_p1     = rand_block();
        bpu_meta   = rand_meta();
        accept_blocks();
        commit_blocks(1'b1);

        // Flush keeps the two oldest blocks
        test_name = "flush";
        push_blocks(5);
        accept_blocks();
        next_cycle();
        flush    = 1'b1;
        flush_id = m_comm + PW'(1);
        push_blocks(2);
        accept_blocks();
        commit_blocks(1'b0);

        // Training after a backend target update
        test_name = "training";
        next_cycle();
        bpu_p0 = rand_block();
        next_cycle();
        bpu_p1   = rand_block();
        bpu_meta = rand_meta();
        next_cycle();
        upd_valid = 1'b1;
        upd_id    = m_bpu - PW'(1);
        upd_jump  = $urandom;
        upd_fall  = $urandom;
        accept_blocks();
        commit_blocks(1'b1);

        test_name = "random";
        random_traffic(300);
        accept_blocks();
        commit_blocks(1'b0);
        repeat (2) next_cycle();

        if (redirects_seen == 0) begin
            errors++;
            $display("No front end redirect was raised during the run");
        end
        if (fulls_seen == 0) begin
            errors++;
            $display("Queue never reported full during the run");
        end
        if (trains_seen == 0) begin
            errors++;
            $display("No training record appeared during the run");
        end
        $display("Checks: %0d cycles, errors: %0d, redirects: %0d, trains: %0d",
                 checks, errors, redirects_seen, trains_seen);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset spans four rising edges and drops just after the fourth
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule
